// File: csr_golden.txt
# n mret ecall re we addr wdata epc | rdata trap_pc redirect tint  (hex, n = cycles held)
# r = LFSR random value, f = expectation from the checker's register model
1 0 0 1 0 300 0 0 a00001800 0 0 0
1 0 0 1 0 304 0 0 80 0 0 0
1 0 0 1 0 305 0 0 0 0 0 0
1 0 0 1 0 341 0 0 0 0 0 0
1 0 0 1 0 342 0 0 0 0 0 0
1 0 0 1 0 344 0 0 0 0 0 0
1 0 0 1 0 7c0 0 0 0 0 0 0
1 0 0 0 1 305 r 0 0 0 0 0
1 0 0 1 0 305 0 0 f 0 0 0
1 0 0 0 1 341 r 0 0 0 0 0
1 0 0 1 0 341 0 0 f 0 0 0
1 0 0 0 1 342 5a5a 0 0 0 0 0
1 0 0 1 0 342 0 0 5a5a 0 0 0
1 0 0 0 1 344 800 0 0 0 0 0
1 0 0 1 0 344 0 0 800 0 0 0
1 0 0 0 1 304 88 0 0 0 0 0
1 0 0 1 0 304 0 0 88 0 0 0
1 0 0 0 1 300 a00001888 0 0 0 0 0
1 0 0 1 0 300 0 0 a00001888 0 0 0
1 0 1 0 1 342 1234 r 0 f 1 0
1 0 0 1 0 341 0 0 f 0 0 0
1 0 0 1 0 342 0 0 b 0 0 0
1 1 1 0 0 0 0 0 0 f 1 0
1 0 0 1 0 342 0 0 b 0 0 0
1 0 0 1 0 300 0 0 a00001888 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 4000 0 f 1 1
1 0 0 1 0 342 0 0 8000000000000007 0 0 0
1 0 0 1 0 300 0 0 a00001880 0 0 0
1 0 0 1 0 344 0 0 880 0 0 0
1 0 0 1 0 341 0 0 4000 0 0 0
28 0 0 0 0 0 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 4000 1 0
1 0 0 1 0 300 0 0 a00001888 0 0 0
1 0 0 1 0 344 0 0 800 0 0 0
1 0 0 0 1 300 a00001880 0 0 0 0 0
96 0 0 0 0 0 0 0 0 0 0 0
1 0 0 1 0 300 0 0 a00001880 0 0 0

// File: filelist.f
+incdir+.
csr_pkg.sv
trap_pkg.sv
trap_if.sv
csr_file.sv
trap_ctrl.sv
clint_timer.sv
csr_unit_top.sv
csr_checker.sv
tb_csr_unit.sv

// File: Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - csr_pkg.sv
  - trap_pkg.sv
  - trap_if.sv
  - csr_file.sv
  - trap_ctrl.sv
  - clint_timer.sv
  - csr_unit_top.sv
  - target: test
    files:
      - csr_checker.sv
      - tb_csr_unit.sv

// File: tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module tb_csr_unit;
    localparam logic [31:0] SEED = 32'h57ad5210;

    logic             clk;
    logic             rst;
    logic [11:0]      csr_addr;
    logic             csr_re, csr_we, mret, ecall;
    logic [`XLEN-1:0] csr_wdata, epc, csr_rdata, trap_pc;
    logic             redirect, tint;
    logic             active;
    logic [`XLEN-1:0] exp_rdata, exp_trap_pc;
    logic             exp_redirect, exp_tint, fol_rdata, fol_trap_pc;
    logic [31:0]      lfsr = SEED;
    int               limit = 0;
    int               cycles = 0;
    bit               file_ok = 1'b1;

    // One entry per golden line
    int               n_q[$];
    logic [3:0]       ctl_q[$];   // mret ecall re we
    logic [11:0]      addr_q[$];
    logic [`XLEN-1:0] wd_q[$];
    logic [`XLEN-1:0] epc_q[$];
    logic [`XLEN-1:0] rd_q[$];
    logic [`XLEN-1:0] pc_q[$];
    logic [1:0]       out_q[$];   // redirect tint
    logic [3:0]       tag_q[$];   // rand wdata, rand epc, follow rdata, follow trap_pc

    csr_unit_top i_dut (
        .clk(clk), .rst(rst), .csr_addr(csr_addr), .csr_re(csr_re), .csr_we(csr_we),
        .csr_wdata(csr_wdata), .mret(mret), .ecall(ecall), .epc(epc),
        .csr_rdata(csr_rdata), .trap_pc(trap_pc), .redirect(redirect), .tint(tint)
    );

    csr_checker i_checker (
        .clk(clk), .rst(rst), .active(active), .mret(mret), .ecall(ecall),
        .csr_re(csr_re), .csr_we(csr_we), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .epc(epc), .csr_rdata(csr_rdata), .trap_pc(trap_pc), .redirect(redirect),
        .tint(tint), .exp_rdata(exp_rdata), .exp_trap_pc(exp_trap_pc),
        .exp_redirect(exp_redirect), .exp_tint(exp_tint), .fol_rdata(fol_rdata),
        .fol_trap_pc(fol_trap_pc)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [`XLEN-1:0] rand64();
        logic [`XLEN-1:0] v;
        v = '0;
        for (int i = 0; i < `XLEN; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[`XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [`XLEN-1:0] hex_field(input string s);
        logic [`XLEN-1:0] v;
        v = '0;
        if (s != "r" && s != "f")
            void'($sscanf(s, "%h", v));
        return v;
    endfunction

    task automatic read_golden();
        int          fd, n, cnt;
        string       line, s_wd, s_epc, s_rd, s_pc;
        logic        m, e, re, we, red, ti;
        logic [11:0] a;
        fd = $fopen("csr_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file csr_golden.txt could not be opened");
            file_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%d %h %h %h %h %h %s %s %s %s %h %h", n, m, e, re, we,
                              a, s_wd, s_epc, s_rd, s_pc, red, ti);
                if (cnt == 12) begin
                    n_q.push_back(n);
                    ctl_q.push_back({m, e, re, we});
                    addr_q.push_back(a);
                    wd_q.push_back(hex_field(s_wd));
                    epc_q.push_back(hex_field(s_epc));
                    rd_q.push_back(hex_field(s_rd));
                    pc_q.push_back(hex_field(s_pc));
                    out_q.push_back({red, ti});
                    tag_q.push_back({s_wd == "r", s_epc == "r", s_rd == "f", s_pc == "f"});
                end else begin
                    $display("malformed golden line: %s", line);
                    file_ok = 1'b0;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the stimulus did not finish", cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        int total;
        rst = 1'b1;
        {mret, ecall, csr_re, csr_we} = '0;
        csr_addr = '0;
        csr_wdata = '0;
        epc = '0;
        active = 1'b0;
        {exp_rdata, exp_trap_pc, exp_redirect, exp_tint, fol_rdata, fol_trap_pc} = '0;
        read_golden();
        total = 0;
        foreach (n_q[i])
            total += n_q[i];
        limit = 2 * total + 20;
        repeat (5) @(posedge clk);
        foreach (n_q[i]) begin
            repeat (n_q[i]) begin
                @(negedge clk);
                rst    = 1'b0;
                active = 1'b1;
                {mret, ecall, csr_re, csr_we} = ctl_q[i];
                csr_addr  = addr_q[i];
                csr_wdata = tag_q[i][3] ? rand64() : wd_q[i];
                epc       = tag_q[i][2] ? rand64() : epc_q[i];
                {fol_rdata, fol_trap_pc}  = tag_q[i][1:0];
                {exp_redirect, exp_tint}  = out_q[i];
                exp_rdata   = rd_q[i];
                exp_trap_pc = pc_q[i];
            end
        end
        @(negedge clk);
        active = 1'b0;
        {mret, ecall, csr_re, csr_we} = '0;
        @(negedge clk);
        $display("checks %0d errors %0d", i_checker.checks, i_checker.errors);
        if (file_ok && i_checker.errors == 0 && i_checker.checks > 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              active,
    input  logic              mret,
    input  logic              ecall,
    input  logic              csr_re,
    input  logic              csr_we,
    input  logic [11:0]       csr_addr,
    input  logic [`XLEN-1:0]  csr_wdata,
    input  logic [`XLEN-1:0]  epc,
    input  logic [`XLEN-1:0]  csr_rdata,
    input  logic [`XLEN-1:0]  trap_pc,
    input  logic              redirect,
    input  logic              tint,
    input  logic [`XLEN-1:0]  exp_rdata,
    input  logic [`XLEN-1:0]  exp_trap_pc,
    input  logic              exp_redirect,
    input  logic              exp_tint,
    input  logic              fol_rdata,
    input  logic              fol_trap_pc
);
    import csr_pkg::*;
    import trap_pkg::*;

    int errors = 0;
    int checks = 0;

    // Reference model of the CSRs and the timer
    logic [`XLEN-1:0] mstatus, mie, mtvec, mepc, mcause, mip;
    logic [`XLEN-1:0] m_rd, m_pc;
    int               cnt;
    logic             fire;
    trap_event_e      ev;

    function automatic logic [`XLEN-1:0] reg_value(input logic [11:0] a);
        case (a)
            MSTATUS: return mstatus;
            MIE:     return mie;
            MTVEC:   return mtvec;
            MEPC:    return mepc;
            MCAUSE:  return mcause;
            MIP:     return mip;
            default: return '0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [`XLEN-1:0] got,
                           input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED time %0t signal %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Sample just before the rising edge
    always @(negedge clk) begin
        #18;
        if (rst) begin
            mstatus = `MSTATUS_RESET;
            mie     = `MIE_RESET;
            mtvec   = '0;
            mepc    = '0;
            mcause  = '0;
            mip     = '0;
            cnt     = 0;
        end else begin
            fire = (cnt == `CLINT_PERIOD - 1) && mstatus[3] && mie[7] && !mip[7];
            ev   = mret ? EV_MRET : ecall ? EV_ECALL : fire ? EV_TIMER : EV_NONE;
            m_rd = csr_re ? reg_value(csr_addr) : '0;
            m_pc = (ev == EV_MRET) ? mepc : (ev != EV_NONE) ? mtvec : '0;
            if (active) begin
                compare("csr_rdata", csr_rdata, fol_rdata ? m_rd : exp_rdata);
                compare("trap_pc", trap_pc, fol_trap_pc ? m_pc : exp_trap_pc);
                compare("redirect", redirect, exp_redirect);
                compare("tint", tint, exp_tint);
            end
            // Model state after the edge
            if (ev == EV_MRET) begin
                mstatus[3] = mstatus[7];
                mstatus[7] = 1'b1;
                mip[7]     = 1'b0;
            end else if (ev != EV_NONE) begin
                mepc   = epc;
                mcause = (ev == EV_ECALL) ? 64'd11 : {1'b1, 63'd7};
                if (ev == EV_TIMER) begin
                    mstatus[7] = mstatus[3];
                    mstatus[3] = 1'b0;
                    mip[7]     = 1'b1;
                end
            end else if (csr_we) begin
                case (csr_addr)
                    MSTATUS: mstatus = csr_wdata;
                    MIE:     mie     = csr_wdata;
                    MTVEC:   mtvec   = csr_wdata;
                    MEPC:    mepc    = csr_wdata;
                    MCAUSE:  mcause  = csr_wdata;
                    MIP:     mip     = csr_wdata;
                    default: ;
                endcase
            end
            cnt = (cnt == `CLINT_PERIOD - 1) ? 0 : cnt + 1;
        end
    end

endmodule

`default_nettype wire

// File: csr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_unit_top (
    input  logic              clk,
    input  logic              rst,
    input  logic [11:0]       csr_addr,
    input  logic              csr_re,
    input  logic              csr_we,
    input  logic [`XLEN-1:0]  csr_wdata,
    input  logic              mret,
    input  logic              ecall,
    input  logic [`XLEN-1:0]  epc,
    output logic [`XLEN-1:0]  csr_rdata,
    output logic [`XLEN-1:0]  trap_pc,
    output logic              redirect,
    output logic              tint
);
    import csr_pkg::*;

    logic timer_fire;

    trap_if trap ();

    csr_file i_csr_file (
        .clk       (clk),
        .rst       (rst),
        .csr_addr  (csr_addr_e'(csr_addr)),
        .csr_re    (csr_re),
        .csr_we    (csr_we),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .trap      (trap.regs)
    );

    trap_ctrl i_trap_ctrl (
        .mret       (mret),
        .ecall      (ecall),
        .timer_fire (timer_fire),
        .epc        (epc),
        .trap_pc    (trap_pc),
        .redirect   (redirect),
        .tint       (tint),
        .trap       (trap.ctrl),
        .clk        (clk),
        .rst        (rst)
    );

    clint_timer i_clint_timer (
        .clk        (clk),
        .rst        (rst),
        .trap       (trap.timer),
        .timer_fire (timer_fire)
    );

endmodule

`default_nettype wire

// File: clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module clint_timer (
    input  logic  clk,
    input  logic  rst,
    trap_if.timer trap,
    output logic  timer_fire
);
    localparam int CNT_W = $clog2(`CLINT_PERIOD);

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_W'(`CLINT_PERIOD - 1));

    // Free-running, no reload from software
    always_ff @(posedge clk) begin
        if (rst)
            cnt <= '0;
        else if (wrap)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // Suppressed wraps are simply lost
    assign timer_fire = wrap
                      && trap.status_mie
                      && trap.mie_mtie
                      && !trap.mip_mtip; // Still pending from last fire

    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        timer_fire |=> !timer_fire);

endmodule

`default_nettype wire

// File: trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module trap_ctrl (
    input  logic              mret,
    input  logic              ecall,
    input  logic              timer_fire,
    input  logic [`XLEN-1:0]  epc,
    output logic [`XLEN-1:0]  trap_pc,
    output logic              redirect,
    output logic              tint,
    trap_if.ctrl              trap,
    input  logic              clk,
    input  logic              rst
);
    import trap_pkg::*;

    trap_event_e ev;

    // mret > ecall > timer
    always_comb begin
        if (mret)
            ev = EV_MRET;
        else if (ecall)
            ev = EV_ECALL;
        else if (timer_fire)
            ev = EV_TIMER;
        else
            ev = EV_NONE;
    end

    always_comb begin
        case (ev)
            EV_MRET:           trap_pc = trap.mepc;
            EV_ECALL, EV_TIMER: trap_pc = trap.mtvec;
            default:           trap_pc = '0;
        endcase
    end

    assign redirect        = (ev != EV_NONE);
    assign tint            = (ev == EV_TIMER);
    assign trap.trap_event = ev;
    assign trap.trap_epc   = epc;

    a_tint_redirect: assert property (@(posedge clk) tint |-> redirect);

    // Strobes and the timer are quiet while in reset
    a_no_redirect_rst: assert property (@(posedge clk) rst |-> !redirect);

endmodule

`default_nettype wire

// File: csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_file (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_addr_e    csr_addr,
    input  logic                  csr_re,
    input  logic                  csr_we,
    input  logic [`XLEN-1:0]      csr_wdata,
    output logic [`XLEN-1:0]      csr_rdata,
    trap_if.regs                  trap
);
    import csr_pkg::*;
    import trap_pkg::*;

    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mie;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mip;

    csr_sel_e   sel;
    logic [5:0] rd_hit;

    // Address decode
    always_comb begin
        unique case (csr_addr)
            MSTATUS: sel = SEL_MSTATUS;
            MIE:     sel = SEL_MIE;
            MTVEC:   sel = SEL_MTVEC;
            MEPC:    sel = SEL_MEPC;
            MCAUSE:  sel = SEL_MCAUSE;
            MIP:     sel = SEL_MIP;
            default: sel = SEL_NONE;
        endcase
    end

    assign rd_hit = {6{csr_re}} & {sel == SEL_MIP,
                                   sel == SEL_MCAUSE,
                                   sel == SEL_MEPC,
                                   sel == SEL_MTVEC,
                                   sel == SEL_MIE,
                                   sel == SEL_MSTATUS};

    // One-hot read mux, zero on miss
    assign csr_rdata = ({`XLEN{rd_hit[0]}} & mstatus)
                     | ({`XLEN{rd_hit[1]}} & mie)
                     | ({`XLEN{rd_hit[2]}} & mtvec)
                     | ({`XLEN{rd_hit[3]}} & mepc)
                     | ({`XLEN{rd_hit[4]}} & mcause)
                     | ({`XLEN{rd_hit[5]}} & mip);

    // Trap events win over software writes
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= `MSTATUS_RESET;
            mie     <= `MIE_RESET;
            mtvec   <= `MTVEC_RESET;
            mepc    <= `MEPC_RESET;
            mcause  <= '0;
            mip     <= '0;
        end else if (trap.trap_event == EV_MRET) begin
            mstatus[`MSTATUS_MIE_BIT]  <= mstatus[`MSTATUS_MPIE_BIT];
            mstatus[`MSTATUS_MPIE_BIT] <= 1'b1;
            mip[`MTIP_BIT]             <= 1'b0;
        end else if (trap.trap_event == EV_ECALL) begin
            mepc   <= trap.trap_epc;
            mcause <= CAUSE_ECALL_M;
        end else if (trap.trap_event == EV_TIMER) begin
            mepc                       <= trap.trap_epc;
            mcause                     <= CAUSE_M_TIMER;
            mstatus[`MSTATUS_MPIE_BIT] <= mstatus[`MSTATUS_MIE_BIT];
            mstatus[`MSTATUS_MIE_BIT]  <= 1'b0;
            mip[`MTIP_BIT]             <= 1'b1; // Pending until mret
        end else if (csr_we) begin
            case (sel)
                SEL_MSTATUS: mstatus <= csr_wdata;
                SEL_MIE:     mie     <= csr_wdata;
                SEL_MTVEC:   mtvec   <= csr_wdata;
                SEL_MEPC:    mepc    <= csr_wdata;
                SEL_MCAUSE:  mcause  <= csr_wdata;
                SEL_MIP:     mip     <= csr_wdata;
                default:     ; // Unknown address ignored
            endcase
        end
    end

    assign trap.status_mie = mstatus[`MSTATUS_MIE_BIT];
    assign trap.mie_mtie   = mie[`MTIP_BIT];
    assign trap.mip_mtip   = mip[`MTIP_BIT];
    assign trap.mtvec      = mtvec;
    assign trap.mepc       = mepc;

    a_write_sel: assert property (@(posedge clk) disable iff (rst)
        (csr_we && trap.trap_event == EV_NONE &&
         csr_addr inside {MSTATUS, MIE, MTVEC, MEPC, MCAUSE, MIP}) |-> sel != SEL_NONE);

endmodule

`default_nettype wire

// File: trap_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

interface trap_if;
    import trap_pkg::*;

    trap_event_e       trap_event; // Ranked event of this cycle
    logic [`XLEN-1:0]  trap_epc;

    // Status and vectors from the CSR file
    logic              status_mie;
    logic              mie_mtie;
    logic              mip_mtip;
    logic [`XLEN-1:0]  mtvec;
    logic [`XLEN-1:0]  mepc;

    modport ctrl  (output trap_event, trap_epc, input mtvec, mepc);
    modport regs  (input trap_event, trap_epc,
                   output status_mie, mie_mtie, mip_mtip, mtvec, mepc);
    modport timer (input status_mie, mie_mtie, mip_mtip);

endinterface

`default_nettype wire

// File: trap_pkg.sv
`default_nettype none

`include "csr_consts.svh"

package trap_pkg;

    // mcause values, interrupt flag in the top bit
    typedef enum logic [`XLEN-1:0] {
        CAUSE_ECALL_M = `XLEN'(11),
        CAUSE_M_TIMER = {1'b1, (`XLEN-1)'(7)}
    } trap_cause_e;

    typedef enum logic [1:0] {
        EV_NONE,
        EV_MRET,
        EV_ECALL,
        EV_TIMER
    } trap_event_e;

endpackage

`default_nettype wire

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Supported machine CSR addresses
    typedef enum logic [11:0] {
        MSTATUS = 12'h300,
        MIE     = 12'h304,
        MTVEC   = 12'h305,
        MEPC    = 12'h341,
        MCAUSE  = 12'h342,
        MIP     = 12'h344
    } csr_addr_e;

    // Decoded register select
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_MSTATUS,
        SEL_MIE,
        SEL_MTVEC,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MIP
    } csr_sel_e;

endpackage

`default_nettype wire

// File: csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Register width
`define XLEN 64

// Reset values, MPP = machine mode
`define MSTATUS_RESET 64'ha00001800
`define MIE_RESET     64'h80 // MTIE set
`define MTVEC_RESET   64'h0
`define MEPC_RESET    64'h0

// Timer period in cycles
`define CLINT_PERIOD 32

`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MTIP_BIT         7 // Also MTIE in mie

`endif
